// ==== include/muldiv_defines.svh ====
`ifndef MULDIV_DEFINES_SVH
`define MULDIV_DEFINES_SVH

// operand and result width, rv32 only
`define MULDIV_XLEN 32

// width of the issue-stage transaction tag
`define MULDIV_ID_BITS 3

// multiplier latency from accept to result, in cycles
`define MULDIV_MUL_STAGES 2

`endif

// ==== hw/muldiv_pkg.sv ====
`default_nettype none

`include "muldiv_defines.svh"

package muldiv_pkg;

  // one operand or one result word
  typedef logic [`MULDIV_XLEN-1:0] xlen_t;

  // tag that follows an operation from issue to writeback
  typedef logic [`MULDIV_ID_BITS-1:0] trans_id_t;

  // operations of the m extension, word forms not supported
  typedef enum logic [2:0] {
    MUL,
    MULH,
    MULHU,
    MULHSU,
    DIV,
    DIVU,
    REM,
    REMU
  } muldiv_op_e;

  // serial divider control
  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    ITERATE,
    FIXUP,
    DONE
  } div_state_e;

endpackage

`default_nettype wire

// ==== hw/mul_pipe.sv ====
`default_nettype none

`include "muldiv_defines.svh"

module mul_pipe (
  input  wire logic                  clk_i,
  input  wire logic                  rst_n_i,
  input  wire logic                  in_valid_i,
  input  muldiv_pkg::muldiv_op_e     op_i,
  input  muldiv_pkg::xlen_t          operand_a_i,
  input  muldiv_pkg::xlen_t          operand_b_i,
  input  muldiv_pkg::trans_id_t      trans_id_i,
  output logic                       out_valid_o,
  output muldiv_pkg::xlen_t          result_o,
  output muldiv_pkg::trans_id_t      trans_id_o
);

  localparam int unsigned XLEN = `MULDIV_XLEN;

  // per-operand sign treatment picked from the op
  logic                  a_signed;
  logic                  b_signed;

  // stage one, operands widened by one sign bit
  logic                  s1_valid_q;
  logic [XLEN:0]         s1_a_q;
  logic [XLEN:0]         s1_b_q;
  logic                  s1_high_q;
  muldiv_pkg::trans_id_t s1_id_q;

  // stage two, full double-width product
  logic [2*XLEN-1:0]     a_wide;
  logic [2*XLEN-1:0]     b_wide;
  logic                  s2_valid_q;
  logic [2*XLEN-1:0]     s2_prod_q;
  logic                  s2_high_q;
  muldiv_pkg::trans_id_t s2_id_q;

  // mulh treats both as signed, mulhsu only a
  assign a_signed = (op_i == muldiv_pkg::MULH) || (op_i == muldiv_pkg::MULHSU);
  assign b_signed = (op_i == muldiv_pkg::MULH);

  // sign extend to full width so the low 2*xlen bits of the product are exact
  assign a_wide = {{(XLEN-1){s1_a_q[XLEN]}}, s1_a_q};
  assign b_wide = {{(XLEN-1){s1_b_q[XLEN]}}, s1_b_q};

  // ------------------------------
  // valid pipeline
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= in_valid_i;
      s2_valid_q <= s1_valid_q;
    end
  end

  // ------------------------------
  // payload pipeline
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (in_valid_i) begin
      s1_a_q    <= {a_signed & operand_a_i[XLEN-1], operand_a_i};
      s1_b_q    <= {b_signed & operand_b_i[XLEN-1], operand_b_i};
      // only plain mul wants the low word
      s1_high_q <= (op_i != muldiv_pkg::MUL);
      s1_id_q   <= trans_id_i;
    end
    if (s1_valid_q) begin
      s2_prod_q <= a_wide * b_wide;
      s2_high_q <= s1_high_q;
      s2_id_q   <= s1_id_q;
    end
  end

  assign out_valid_o = s2_valid_q;
  assign result_o    = s2_high_q ? s2_prod_q[2*XLEN-1:XLEN] : s2_prod_q[XLEN-1:0];
  assign trans_id_o  = s2_id_q;

  // fixed latency, in both directions
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    in_valid_i |-> ##(`MULDIV_MUL_STAGES) out_valid_o);
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o |-> $past(in_valid_i, `MULDIV_MUL_STAGES));

endmodule

`default_nettype wire

// ==== hw/serial_divider.sv ====
`default_nettype none

`include "muldiv_defines.svh"

module serial_divider (
  input  wire logic             clk_i,
  input  wire logic             rst_n_i,
  input  wire logic             flush_i,
  input  wire logic             in_valid_i,
  input  wire logic             signed_i,
  input  wire logic             rem_i,
  input  muldiv_pkg::xlen_t     operand_a_i,
  input  muldiv_pkg::xlen_t     operand_b_i,
  input  muldiv_pkg::trans_id_t trans_id_i,
  input  wire logic             out_ready_i,
  output logic                  in_ready_o,
  output logic                  out_valid_o,
  output muldiv_pkg::xlen_t     result_o,
  output muldiv_pkg::trans_id_t trans_id_o
);

  localparam int unsigned XLEN     = `MULDIV_XLEN;
  localparam int unsigned CNT_BITS = $clog2(XLEN);

  // shift step counter
  typedef logic [CNT_BITS-1:0] step_cnt_t;

  muldiv_pkg::div_state_e state_q;
  muldiv_pkg::div_state_e state_d;
  step_cnt_t              step_q;

  // quo_q holds the dividend until it is shifted out, then the quotient
  muldiv_pkg::xlen_t      quo_q;
  muldiv_pkg::xlen_t      divisor_q;
  // partial remainder
  muldiv_pkg::xlen_t      acc_q;
  muldiv_pkg::xlen_t      res_q;
  muldiv_pkg::trans_id_t  id_q;
  logic                   signed_q;
  logic                   rem_sel_q;
  logic                   neg_quo_q;
  logic                   neg_rem_q;

  logic [XLEN:0]          acc_shift;
  logic [XLEN:0]          acc_diff;
  logic                   acc_ge;
  logic                   a_neg;
  logic                   b_neg;
  muldiv_pkg::xlen_t      quo_fix;
  muldiv_pkg::xlen_t      rem_fix;

  // one restoring step, shift in next dividend bit and trial subtract
  assign acc_shift = {acc_q, quo_q[XLEN-1]};
  assign acc_ge    = (acc_shift >= {1'b0, divisor_q});
  assign acc_diff  = acc_shift - {1'b0, divisor_q};

  // sign bits of the raw operands, only meaningful in LOAD
  assign a_neg = signed_q & quo_q[XLEN-1];
  assign b_neg = signed_q & divisor_q[XLEN-1];

  // restore signs after the unsigned core
  assign quo_fix = neg_quo_q ? -quo_q : quo_q;
  assign rem_fix = neg_rem_q ? -acc_q : acc_q;

  // ------------------------------
  // control FSM
  // ------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      muldiv_pkg::IDLE: begin
        if (in_valid_i) begin
          state_d = muldiv_pkg::LOAD;
        end
      end
      muldiv_pkg::LOAD: state_d = muldiv_pkg::ITERATE;
      muldiv_pkg::ITERATE: begin
        if (step_q == step_cnt_t'(XLEN-1)) begin
          state_d = muldiv_pkg::FIXUP;
        end
      end
      muldiv_pkg::FIXUP: state_d = muldiv_pkg::DONE;
      // result held until the output side is free
      muldiv_pkg::DONE: begin
        if (out_ready_i) begin
          state_d = muldiv_pkg::IDLE;
        end
      end
      default: state_d = muldiv_pkg::IDLE;
    endcase
    // flush drops whatever is in flight
    if (flush_i) begin
      state_d = muldiv_pkg::IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= muldiv_pkg::IDLE;
      step_q  <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == muldiv_pkg::LOAD) begin
        step_q <= '0;
      end else if (state_q == muldiv_pkg::ITERATE) begin
        step_q <= step_q + 1'b1;
      end
    end
  end

  // ------------------------------
  // datapath
  // ------------------------------
  always_ff @(posedge clk_i) begin
    case (state_q)
      muldiv_pkg::IDLE: begin
        if (in_valid_i) begin
          quo_q     <= operand_a_i;
          divisor_q <= operand_b_i;
          signed_q  <= signed_i;
          rem_sel_q <= rem_i;
          id_q      <= trans_id_i;
        end
      end
      muldiv_pkg::LOAD: begin
        // magnitudes in place, most negative value maps onto itself
        quo_q     <= a_neg ? -quo_q : quo_q;
        divisor_q <= b_neg ? -divisor_q : divisor_q;
        acc_q     <= '0;
        // divide by zero keeps the all-ones quotient unnegated
        neg_quo_q <= (a_neg ^ b_neg) & (divisor_q != '0);
        neg_rem_q <= a_neg;
      end
      muldiv_pkg::ITERATE: begin
        acc_q <= acc_ge ? acc_diff[XLEN-1:0] : acc_shift[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], acc_ge};
      end
      muldiv_pkg::FIXUP: begin
        res_q <= rem_sel_q ? rem_fix : quo_fix;
      end
      default: begin
      end
    endcase
  end

  assign in_ready_o  = (state_q == muldiv_pkg::IDLE);
  assign out_valid_o = (state_q == muldiv_pkg::DONE);
  assign result_o    = res_q;
  assign trans_id_o  = id_q;

  // a stalled result must not change or vanish
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_o && !out_ready_i && !flush_i) |=>
      (out_valid_o && $stable(result_o) && $stable(trans_id_o)));
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(in_ready_o && out_valid_o));

endmodule

`default_nettype wire

// ==== hw/muldiv_unit.sv ====
`default_nettype none

module muldiv_unit (
  input  wire logic             clk_i,
  input  wire logic             rst_n_i,
  input  wire logic             flush_i,
  input  wire logic             valid_i,
  input  muldiv_pkg::muldiv_op_e op_i,
  input  muldiv_pkg::xlen_t     operand_a_i,
  input  muldiv_pkg::xlen_t     operand_b_i,
  input  muldiv_pkg::trans_id_t trans_id_i,
  output logic                  ready_o,
  output logic                  valid_o,
  output muldiv_pkg::xlen_t     result_o,
  output muldiv_pkg::trans_id_t trans_id_o
);

  // decode
  logic                  is_mul;
  logic                  is_div;
  logic                  mul_in_valid;
  logic                  div_in_valid;
  logic                  div_signed;
  logic                  div_rem;

  // unit results
  logic                  mul_valid;
  muldiv_pkg::xlen_t     mul_result;
  muldiv_pkg::trans_id_t mul_id;
  logic                  div_valid;
  logic                  div_out_ready;
  muldiv_pkg::xlen_t     div_result;
  muldiv_pkg::trans_id_t div_id;

  // ------------------------------
  // issue decode
  // ------------------------------
  assign is_mul = op_i inside {muldiv_pkg::MUL, muldiv_pkg::MULH,
                               muldiv_pkg::MULHU, muldiv_pkg::MULHSU};
  assign is_div = op_i inside {muldiv_pkg::DIV, muldiv_pkg::DIVU,
                               muldiv_pkg::REM, muldiv_pkg::REMU};

  // flush blocks issue to both units
  assign mul_in_valid = valid_i & ~flush_i & is_mul;
  assign div_in_valid = valid_i & ~flush_i & is_div;

  assign div_signed = op_i inside {muldiv_pkg::DIV, muldiv_pkg::REM};
  assign div_rem    = op_i inside {muldiv_pkg::REM, muldiv_pkg::REMU};

  mul_pipe i_mul_pipe (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (mul_in_valid),
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .trans_id_i  (trans_id_i),
    .out_valid_o (mul_valid),
    .result_o    (mul_result),
    .trans_id_o  (mul_id)
  );

  serial_divider i_serial_divider (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (div_in_valid),
    .signed_i    (div_signed),
    .rem_i       (div_rem),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .trans_id_i  (trans_id_i),
    .out_ready_i (div_out_ready),
    .in_ready_o  (ready_o),
    .out_valid_o (div_valid),
    .result_o    (div_result),
    .trans_id_o  (div_id)
  );

  // ------------------------------
  // result arbitration
  // ------------------------------
  // multiplier cannot stall so it always wins, divider waits
  assign div_out_ready = ~mul_valid;
  assign valid_o       = mul_valid | div_valid;
  assign result_o      = mul_valid ? mul_result : div_result;
  assign trans_id_o    = mul_valid ? mul_id : div_id;

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    div_in_valid |-> ready_o);
  // a divider result that meets a multiplier result is still there next cycle
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (div_valid && mul_valid && !flush_i) |=> div_valid);

endmodule

`default_nettype wire

// ==== dv/muldiv_tb.sv ====
`default_nettype none

`include "muldiv_defines.svh"

module muldiv_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int XLEN = `MULDIV_XLEN;
  localparam int CLK_PERIOD = 10;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;
  localparam muldiv_pkg::xlen_t MIN_NEG = {1'b1, {(XLEN-1){1'b0}}};
  // operation counts per test
  localparam int N_MUL = 64;
  localparam int N_DIV = 24;
  localparam int N_CORNER = 8;
  localparam int N_COLL = 4;
  localparam int N_FLUSH = 4;
  localparam int N_OPS = N_MUL + N_DIV + N_CORNER + N_COLL * 5 + N_FLUSH * 2;
  localparam int TIMEOUT_NS = N_OPS * 40 * CLK_PERIOD + 2000;
  localparam int WAIT_CYCLES = 60;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   flush_i;
  logic                   valid_i;
  muldiv_pkg::muldiv_op_e op_i;
  muldiv_pkg::xlen_t      operand_a_i;
  muldiv_pkg::xlen_t      operand_b_i;
  muldiv_pkg::trans_id_t  trans_id_i;
  logic                   ready_o;
  logic                   valid_o;
  muldiv_pkg::xlen_t      result_o;
  muldiv_pkg::trans_id_t  trans_id_o;

  // expected result per id in flight
  muldiv_pkg::xlen_t      exp_sb [muldiv_pkg::trans_id_t];
  logic                   exp_hit;
  muldiv_pkg::xlen_t      exp_val;
  muldiv_pkg::trans_id_t  next_id = '0;
  logic                   mul_issue;
  // issued id delayed by the multiplier latency
  muldiv_pkg::trans_id_t  mul_id_q [`MULDIV_MUL_STAGES];
  logic [31:0]            lfsr_q = 32'hc009;
  int                     errors = 0;
  int                     test_base = 0;
  int                     passed = 0;
  int                     failed = 0;

  muldiv_unit dut_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .trans_id_i  (trans_id_i),
    .ready_o     (ready_o),
    .valid_o     (valid_o),
    .result_o    (result_o),
    .trans_id_o  (trans_id_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog: run timed out after %0d ns", TIMEOUT_NS);
    $display("sim failed");
    $finish;
  end

  // ------------------------------
  // stimulus helpers
  // ------------------------------
  // galois lfsr, one step per random bit
  function automatic muldiv_pkg::xlen_t rand_bits(input int n);
    muldiv_pkg::xlen_t v;
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[XLEN-2:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  // riscv m extension rules
  function automatic muldiv_pkg::xlen_t model(input muldiv_pkg::muldiv_op_e op,
                                              input muldiv_pkg::xlen_t a,
                                              input muldiv_pkg::xlen_t b);
    logic signed [2*XLEN-1:0] prod;
    logic signed [XLEN-1:0]   sa;
    logic signed [XLEN-1:0]   sb;
    muldiv_pkg::xlen_t res;
    logic ovf;
    logic zero;
    sa = a;
    sb = b;
    zero = (b == '0);
    ovf = (a == MIN_NEG) && (b == '1);
    case (op)
      muldiv_pkg::MUL: begin
        prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        res = prod[XLEN-1:0];
      end
      muldiv_pkg::MULH: begin
        prod = $signed({{XLEN{a[XLEN-1]}}, a}) * $signed({{XLEN{b[XLEN-1]}}, b});
        res = prod[2*XLEN-1:XLEN];
      end
      muldiv_pkg::MULHU: begin
        prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        res = prod[2*XLEN-1:XLEN];
      end
      muldiv_pkg::MULHSU: begin
        // b is never negative, so a zero extension keeps its value
        prod = $signed({{XLEN{a[XLEN-1]}}, a}) * $signed({{XLEN{1'b0}}, b});
        res = prod[2*XLEN-1:XLEN];
      end
      // x/0 is all ones, overflow returns the dividend
      muldiv_pkg::DIV: begin
        if (zero) begin
          res = '1;
        end else if (ovf) begin
          res = a;
        end else begin
          res = sa / sb;
        end
      end
      muldiv_pkg::DIVU: res = zero ? '1 : a / b;
      // x%0 is x, overflow remainder is zero
      muldiv_pkg::REM: begin
        if (zero) begin
          res = a;
        end else if (ovf) begin
          res = '0;
        end else begin
          res = sa % sb;
        end
      end
      muldiv_pkg::REMU: res = zero ? a : a % b;
      default: res = '0;
    endcase
    return res;
  endfunction

  task automatic cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic alloc_id(output muldiv_pkg::trans_id_t id);
    int tries;
    tries = 0;
    while (exp_sb.exists(next_id)) begin
      next_id = next_id + 1'b1;
      tries++;
      // every tag busy, let one retire
      if (tries % 8 == 0) begin
        cycle();
      end
    end
    id = next_id;
    next_id = next_id + 1'b1;
  endtask

  task automatic issue_op(input muldiv_pkg::muldiv_op_e op, input muldiv_pkg::xlen_t a,
                          input muldiv_pkg::xlen_t b, output muldiv_pkg::trans_id_t id);
    alloc_id(id);
    exp_sb[id] = model(op, a, b);
    valid_i = 1'b1;
    op_i = op;
    operand_a_i = a;
    operand_b_i = b;
    trans_id_i = id;
    cycle();
    valid_i = 1'b0;
  endtask

  task automatic wait_ready(input int limit);
    int n;
    n = 0;
    while (!ready_o && n < limit) begin
      cycle();
      n++;
    end
    if (!ready_o) begin
      $display("ready_o still low after %0d cycles at %0t", limit, $time);
      errors++;
    end
  endtask

  task automatic issue_div(input muldiv_pkg::muldiv_op_e op, input muldiv_pkg::xlen_t a,
                           input muldiv_pkg::xlen_t b, output muldiv_pkg::trans_id_t id);
    wait_ready(WAIT_CYCLES);
    issue_op(op, a, b, id);
  endtask

  task automatic drain(input int limit);
    int n;
    n = 0;
    while (exp_sb.size() != 0 && n < limit) begin
      cycle();
      n++;
    end
    if (exp_sb.size() != 0) begin
      $display("%0d results never came back within %0d cycles", exp_sb.size(), limit);
      errors++;
      exp_sb.delete();
    end
  endtask

  task automatic end_test(input string name);
    drain(WAIT_CYCLES);
    if (errors == test_base) begin
      passed++;
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: %0d errors", name, errors - test_base);
    end
    test_base = errors;
  endtask

  // ------------------------------
  // scoreboard and checks
  // ------------------------------
  // outputs are stable at the falling edge, retire the id there
  always @(negedge clk_i) begin
    exp_hit = 1'b0;
    if (rst_n_i && valid_o) begin
      exp_hit = (exp_sb.exists(trans_id_o) != 0);
      if (exp_hit) begin
        exp_val = exp_sb[trans_id_o];
        exp_sb.delete(trans_id_o);
      end
    end
  end

  always @(posedge clk_i) begin
    mul_id_q[0] <= trans_id_i;
    for (int s = 1; s < `MULDIV_MUL_STAGES; s++) begin
      mul_id_q[s] <= mul_id_q[s-1];
    end
  end

  assign mul_issue = valid_i && !flush_i && (op_i inside {muldiv_pkg::MUL, muldiv_pkg::MULH,
                                                          muldiv_pkg::MULHU, muldiv_pkg::MULHSU});

  assert property (@(posedge clk_i) $rose(rst_n_i) |-> !valid_o)
    else begin
      errors++;
      $display("ERROR %0t valid_o expected 0 got %b", $time, $sampled(valid_o));
    end
  assert property (@(posedge clk_i) $rose(rst_n_i) |-> ready_o)
    else begin
      errors++;
      $display("ERROR %0t ready_o expected 1 got %b", $time, $sampled(ready_o));
    end
  // a duplicate or a flushed id has no entry left
  assert property (@(posedge clk_i) disable iff (!rst_n_i) valid_o |-> exp_hit)
    else begin
      errors++;
      $display("result for id %0d at %0t was not expected", $sampled(trans_id_o), $time);
    end
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (valid_o && exp_hit) |-> (result_o == exp_val))
    else begin
      errors++;
      $display("ERROR %0t result_o expected %h got %h (id %0d)", $time, exp_val,
               $sampled(result_o), $sampled(trans_id_o));
    end
  // multiplies retire at a fixed latency
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(mul_issue, `MULDIV_MUL_STAGES) |-> valid_o)
    else begin
      errors++;
      $display("multiply result missing at %0t", $time);
    end
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ($past(mul_issue, `MULDIV_MUL_STAGES) && valid_o) |->
      (trans_id_o == mul_id_q[`MULDIV_MUL_STAGES-1]))
    else begin
      errors++;
      $display("ERROR %0t trans_id_o expected %0d got %0d", $time,
               $sampled(mul_id_q[`MULDIV_MUL_STAGES-1]), $sampled(trans_id_o));
    end

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin
    muldiv_pkg::trans_id_t  id;
    muldiv_pkg::trans_id_t  div_id;
    muldiv_pkg::muldiv_op_e op;
    muldiv_pkg::xlen_t      a;
    muldiv_pkg::xlen_t      b;
    int                     k;
    int                     j;
    rst_n_i = 1'b0;
    flush_i = 1'b0;
    valid_i = 1'b0;
    op_i = muldiv_pkg::MUL;
    operand_a_i = '0;
    operand_b_i = '0;
    trans_id_i = '0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    repeat (3) cycle();
    end_test("reset state");

    for (k = 0; k < N_MUL; k++) begin
      op = muldiv_pkg::muldiv_op_e'(3'(rand_bits(2)));
      a = rand_bits(XLEN);
      b = rand_bits(XLEN);
      issue_op(op, a, b, id);
    end
    end_test("multiply stream");

    for (k = 0; k < N_DIV; k++) begin
      op = muldiv_pkg::muldiv_op_e'(3'(4 + rand_bits(2)));
      a = rand_bits(XLEN);
      b = rand_bits(XLEN);
      // shorter divisors give longer quotients
      b = b >> rand_bits(5);
      issue_div(op, a, b, id);
    end
    end_test("random divide");

    // divide by zero and signed overflow in all four forms
    for (k = 0; k < N_CORNER / 2; k++) begin
      op = muldiv_pkg::muldiv_op_e'(3'(4 + k));
      a = rand_bits(XLEN);
      issue_div(op, a, '0, id);
      issue_div(op, MIN_NEG, '1, id);
    end
    end_test("divide corners");

    for (k = 0; k < N_COLL; k++) begin
      op = muldiv_pkg::muldiv_op_e'(3'(4 + rand_bits(2)));
      a = rand_bits(XLEN);
      b = rand_bits(XLEN);
      issue_div(op, a, b, div_id);
      // divider reaches DONE 34 cycles after accept, the four results straddle it
      repeat (28 + k) cycle();
      for (j = 0; j < 4; j++) begin
        op = muldiv_pkg::muldiv_op_e'(3'(rand_bits(2)));
        a = rand_bits(XLEN);
        b = rand_bits(XLEN);
        issue_op(op, a, b, id);
      end
      drain(WAIT_CYCLES);
    end
    end_test("divide collision");

    for (k = 0; k < N_FLUSH; k++) begin
      op = muldiv_pkg::muldiv_op_e'(3'(4 + rand_bits(2)));
      a = rand_bits(XLEN);
      b = rand_bits(XLEN);
      issue_div(op, a, b, div_id);
      repeat (1 + 9 * k) cycle();
      a = rand_bits(XLEN);
      b = rand_bits(XLEN);
      issue_op(muldiv_pkg::MUL, a, b, id);
      // the multiply is already in the pipe when the flush hits
      flush_i = 1'b1;
      exp_sb.delete(div_id);
      cycle();
      flush_i = 1'b0;
      wait_ready(4);
      drain(WAIT_CYCLES);
    end
    end_test("flush");

    $display("tests passed %0d failed %0d, check errors %0d", passed, failed, errors);
    if (failed == 0 && errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
hw/muldiv_pkg.sv
hw/mul_pipe.sv
hw/serial_divider.sv
hw/muldiv_unit.sv
dv/muldiv_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the muldiv testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --timescale 1ns/100ps \
  --top-module muldiv_tb \
  -f sim.f \
  -o muldiv_sim

./obj_dir/muldiv_sim | tee sim.log

# the log is the verdict
if grep -qx "sim passed" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
